// File: rv_core_config.svh
/*
 * RV32I core configuration
 * Widths, memory depth, opcodes and fixed encodings
 */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

`define RV_XLEN       32            // Data and PC width
`define RV_IMEM_AW    8             // Instruction memory word address, 256 words
`define RV_REG_AW     5             // 32 integer registers
`define RV_PC_STEP    4

// Major opcodes handled by the core
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011

`define RV_NOP        32'h0000_0013 // addi x0, x0, 0

`endif

// File: design/rv_core_pkg.sv
/*
 * RV32I core types
 * Word, address and ALU operation types plus the pipeline register layouts
 */
`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;      // Data or instruction word
    typedef logic [`RV_XLEN-1:0]    pc_t;        // Byte address
    typedef logic [`RV_IMEM_AW-1:0] imem_addr_t; // Instruction memory word address
    typedef logic [`RV_REG_AW-1:0]  reg_addr_t;

    // Encoded as {funct7[5], funct3} so decode can pass the fields through
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    // Decoded instruction held between decode and execute
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;   // Second operand from the immediate
        alu_op_e   alu_op;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    // Result on its way to the register file
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: design/rv_fetch.sv
/*
 * Fetch stage
 * Program counter, instruction memory with its load port and the IF/ID register
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_fetch
    import rv_core_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_rst,
    input  wire logic       i_en,
    input  wire logic       i_imem_wen,
    input  wire imem_addr_t i_imem_waddr,
    input  wire word_t      i_imem_data,
    output pc_t             o_pc,
    output word_t           o_instr
);

    localparam int PC_WRAP_W = `RV_IMEM_AW + 2; // Byte address bits covered by the memory

    pc_t                  pc_q;
    pc_t                  pc_next;
    logic [PC_WRAP_W-1:0] pc_low_next;
    word_t                imem [2**`RV_IMEM_AW];
    imem_addr_t           imem_raddr;
    word_t                imem_rdata;
    word_t                if_id_instr;

    // PC wraps at the end of the instruction memory
    assign pc_low_next = pc_q[PC_WRAP_W-1:0] + PC_WRAP_W'(`RV_PC_STEP);
    assign pc_next     = {{(`RV_XLEN-PC_WRAP_W){1'b0}}, pc_low_next};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= '0;
        end else if (i_en) begin
            pc_q <= pc_next;
        end
    end

    // Load port works whether or not the core is running
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr] <= i_imem_data;
        end
    end

    assign imem_raddr = pc_q[PC_WRAP_W-1:2]; // Word index
    assign imem_rdata = imem[imem_raddr];

    // IF/ID register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            if_id_instr <= `RV_NOP;
        end else if (i_en) begin
            if_id_instr <= imem_rdata;
        end
    end

    assign o_pc    = pc_q;
    assign o_instr = if_id_instr;

endmodule

`default_nettype wire

// File: design/rv_decode.sv
/*
 * Decode stage
 * Control decode for OP and OP-IMM, I-type immediate and the ID/EX register
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_decode
    import rv_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  i_rst,
    input  wire logic  i_en,
    input  wire word_t i_instr,
    input  wire word_t i_rs1_data,
    input  wire word_t i_rs2_data,
    output reg_addr_t  o_rs1_addr,
    output reg_addr_t  o_rs2_addr,
    output id_ex_t     o_id_ex
);

    localparam int IMM_W = 12;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       is_op;
    logic       is_op_imm;
    logic       alt_sel;
    word_t      imm;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;

    // Instruction fields
    assign opcode    = i_instr[6:0];
    assign rd        = i_instr[11:7];
    assign funct3    = i_instr[14:12];
    assign rs1       = i_instr[19:15];
    assign rs2       = i_instr[24:20];
    assign funct7_b5 = i_instr[30];

    assign is_op     = (opcode == `RV_OPC_OP);
    assign is_op_imm = (opcode == `RV_OPC_OP_IMM);

    /* funct7 bit 5 selects SRA on both forms, but SUB only on OP.
       On ADDI it is just an immediate bit. */
    always_comb begin
        case (funct3)
            3'b000:  alt_sel = funct7_b5 & is_op;
            3'b101:  alt_sel = funct7_b5;
            default: alt_sel = 1'b0;
        endcase
    end

    assign imm = {{(`RV_XLEN-IMM_W){i_instr[31]}}, i_instr[31:20]}; // Sign-extended I-type

    always_comb begin
        id_ex_d.reg_write = is_op | is_op_imm; // Anything else is a bubble
        id_ex_d.rd        = rd;
        id_ex_d.rs1       = rs1;
        id_ex_d.rs2       = rs2;
        id_ex_d.use_imm   = is_op_imm;
        id_ex_d.alu_op    = alu_op_e'({alt_sel, funct3});
        id_ex_d.rs1_data  = i_rs1_data;
        id_ex_d.rs2_data  = i_rs2_data;
        id_ex_d.imm       = imm;
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            id_ex_q.reg_write <= 1'b0;
        end else if (i_en) begin
            id_ex_q <= id_ex_d;
        end
    end

    assign o_rs1_addr = rs1;
    assign o_rs2_addr = rs2;
    assign o_id_ex    = id_ex_q;

endmodule

`default_nettype wire

// File: design/rv_execute.sv
/*
 * Execute stage
 * Operand forwarding from the older instruction, the ALU and the EX/WB register
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_execute
    import rv_core_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   i_rst,
    input  wire logic   i_en,
    input  wire id_ex_t i_id_ex,
    output ex_wb_t      o_ex_wb
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic               fwd_rs1;
    logic               fwd_rs2;
    word_t              op_a;
    word_t              rs2_val;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    word_t              alu_res;
    ex_wb_t             ex_wb_d;
    ex_wb_t             ex_wb_q;

    // Older instruction sits in EX/WB and has not reached the register file yet
    assign fwd_rs1 = ex_wb_q.reg_write && (ex_wb_q.rd != '0) && (ex_wb_q.rd == i_id_ex.rs1);
    assign fwd_rs2 = ex_wb_q.reg_write && (ex_wb_q.rd != '0) && (ex_wb_q.rd == i_id_ex.rs2);

    assign op_a    = fwd_rs1 ? ex_wb_q.result : i_id_ex.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb_q.result : i_id_ex.rs2_data;
    assign op_b    = i_id_ex.use_imm ? i_id_ex.imm : rs2_val;

    assign shamt   = op_b[SHAMT_W-1:0]; // Shifts use the low bits only

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, (op_a < op_b)};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        ex_wb_d.reg_write = i_id_ex.reg_write;
        ex_wb_d.rd        = i_id_ex.rd;
        ex_wb_d.result    = alu_res;
    end

    // EX/WB register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ex_wb_q.reg_write <= 1'b0;
        end else if (i_en) begin
            ex_wb_q <= ex_wb_d;
        end
    end

    assign o_ex_wb = ex_wb_q;

endmodule

`default_nettype wire

// File: design/rv_regfile_wb.sv
/*
 * Integer register file with writeback
 * Write-through reads for decode and a registered debug read on port 1
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile_wb
    import rv_core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      i_rst,
    input  wire logic      i_en,
    input  wire ex_wb_t    i_ex_wb,
    input  wire reg_addr_t i_rs1_addr,
    input  wire reg_addr_t i_rs2_addr,
    input  wire logic      i_dbg_rd,
    input  wire reg_addr_t i_dbg_addr,
    output word_t          o_rs1_data,
    output word_t          o_rs2_data,
    output word_t          o_dbg_data
);

    localparam int NUM_REGS = 2**`RV_REG_AW;

    word_t     regs [NUM_REGS];
    logic      wr_en;
    reg_addr_t rd1_addr;
    word_t     rd1_data;
    word_t     rd2_data;

    assign wr_en = i_en && i_ex_wb.reg_write && (i_ex_wb.rd != '0); // x0 stays zero

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_ex_wb.rd] <= i_ex_wb.result;
        end
    end

    function automatic word_t read_reg(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && (addr == i_ex_wb.rd)) begin
            val = i_ex_wb.result; // Value being written this cycle
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // Debug unit borrows port 1
    assign rd1_addr = i_dbg_rd ? i_dbg_addr : i_rs1_addr;

    always_comb begin
        rd1_data = read_reg(rd1_addr);
        rd2_data = read_reg(i_rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dbg_data <= '0;
        end else if (i_dbg_rd) begin
            o_dbg_data <= rd1_data;
        end
    end

    assign o_rs1_data = rd1_data;
    assign o_rs2_data = rd2_data;

endmodule

`default_nettype wire

// File: design/rv_core.sv
/*
 * RV32I integer core
 * Four-stage pipeline for OP and OP-IMM with a debug register read
 */
`timescale 1ns/10ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_rst,
    input  wire logic       i_en,
    input  wire logic       i_imem_wen,
    input  wire imem_addr_t i_imem_waddr,
    input  wire word_t      i_imem_data,
    input  wire logic       i_du_rgfile_rd,
    input  wire reg_addr_t  i_regfile_addr,
    output pc_t             o_pc,
    output word_t           o_regfile_data
);

    pc_t       fetch_pc;
    word_t     if_id_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;

    rv_fetch u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .o_pc         (fetch_pc),
        .o_instr      (if_id_instr)
    );

    rv_decode u_decode (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_instr    (if_id_instr),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_id_ex    (id_ex)
    );

    rv_execute u_execute (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_en    (i_en),
        .i_id_ex (id_ex),
        .o_ex_wb (ex_wb)
    );

    rv_regfile_wb u_regfile_wb (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_ex_wb    (ex_wb),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_dbg_rd   (i_du_rgfile_rd),
        .i_dbg_addr (i_regfile_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_regfile_data) // Already registered inside
    );

    // PC seen from outside lags the fetch PC by one cycle
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else begin
            o_pc <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

// File: verif/rv_core_chk.sv
/*
 * Pipeline assertions for rv_core
 * PC hold and step under the run enable, EX/WB idle in reset
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_chk
    import rv_core_pkg::*;
(
    input wire logic clk,
    input wire logic i_rst,
    input wire logic i_en,
    input wire pc_t  i_fetch_pc,
    input wire logic i_wb_write
);

    localparam int PC_W = `RV_IMEM_AW + 2; // PC wraps at the memory size

    a_pc_hold: assert property (@(posedge clk) (!i_rst && !i_en) |=> $stable(i_fetch_pc))
        else $error("PC changed in a cycle with the core held");

    a_pc_step: assert property (@(posedge clk) (!i_rst && i_en) |=>
        (i_fetch_pc[PC_W-1:0] == $past(i_fetch_pc[PC_W-1:0]) + PC_W'(`RV_PC_STEP)))
        else $error("PC did not advance by one instruction");

    a_wb_reset: assert property (@(posedge clk) i_rst |=> !i_wb_write)
        else $error("EX/WB write enable set during reset");

endmodule

bind rv_core rv_core_chk u_chk (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_en       (i_en),
    .i_fetch_pc (fetch_pc),
    .i_wb_write (ex_wb.reg_write)
);

`default_nettype wire

// File: verif/rv_core_tb.sv
/*
 * Testbench for the rv_core pipeline
 * Random OP and OP-IMM programs checked against an in-order ISA model
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int NOP_TAIL     = 4;
    localparam int PC_WRAP      = 4 << `RV_IMEM_AW; // Bytes covered by the memory
    localparam int K_OP         = 0;
    localparam int K_IMM        = 1;
    localparam int K_X0         = 2;
    localparam int K_MIX        = 3;
    localparam int K_OTHER      = 4;

    logic       clk;
    logic       i_rst;
    logic       i_en;
    logic       i_imem_wen;
    imem_addr_t i_imem_waddr;
    word_t      i_imem_data;
    logic       i_du_rgfile_rd;
    reg_addr_t  i_regfile_addr;
    pc_t        o_pc;
    word_t      o_regfile_data;

    logic [31:0] rng;
    word_t       model_regs [32];
    word_t       prog [$];
    int          err_cnt;
    int          test_pass;
    int          test_fail;

    rv_core DUT (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_en           (i_en),
        .i_imem_wen     (i_imem_wen),
        .i_imem_waddr   (i_imem_waddr),
        .i_imem_data    (i_imem_data),
        .i_du_rgfile_rd (i_du_rgfile_rd),
        .i_regfile_addr (i_regfile_addr),
        .o_pc           (o_pc),
        .o_regfile_data (o_regfile_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Mostly x0..x7 so that neighbours depend on each other
    function automatic reg_addr_t rand_src();
        logic [31:0] r;
        r = xorshift();
        return (r[3:0] == 4'd0) ? r[12:8] : {2'b00, r[6:4]};
    endfunction

    function automatic word_t gen_instr(input int kind);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [6:0]  opc;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        int          pick;
        word_t       instr;
        r    = xorshift();
        r2   = xorshift();
        rs1  = rand_src();
        rs2  = rand_src();
        f3   = r[2:0];
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && r[3]) ? 7'h20 : 7'h00; // SUB and SRA
        rd   = (r[12:10] == 3'd0) ? r[17:13] : {2'b00, r[12:10]};
        pick = kind;
        if (kind == K_X0 || kind == K_MIX) begin
            case (r[5:4])
                2'd0:    pick = K_OP;
                2'd1:    pick = K_IMM;
                default: pick = (kind == K_X0 || r[4]) ? K_OTHER : K_OP;
            endcase
            if (kind == K_X0 && r[6]) begin
                rd = '0;
            end
        end
        imm = r2[11:0];
        if (f3 == 3'd1) begin
            imm = {7'h00, r2[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {f7, r2[4:0]};
        end
        case (r[9:7])
            3'd0:    opc = 7'b0000011; // Load
            3'd1:    opc = 7'b0100011; // Store
            3'd2:    opc = 7'b1100011; // Branch
            3'd3:    opc = 7'b1101111; // JAL
            3'd4:    opc = 7'b1100111; // JALR
            3'd5:    opc = 7'b0110111; // LUI
            default: opc = 7'b0010111; // AUIPC
        endcase
        if (pick == K_OP) begin
            instr = {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
        end else if (pick == K_IMM) begin
            instr = {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
        end else begin
            instr = {r2[31:7], opc};
        end
        return instr;
    endfunction

    // RV32I semantics for OP and OP-IMM
    // Any other opcode leaves the registers unchanged
    function automatic void model_exec(input word_t ins);
        word_t      a;
        word_t      b;
        word_t      res;
        logic [4:0] sh;
        logic       is_op;
        logic       is_imm;
        is_op  = (ins[6:0] == `RV_OPC_OP);
        is_imm = (ins[6:0] == `RV_OPC_OP_IMM);
        if (!(is_op || is_imm) || ins[11:7] == 5'd0) begin
            return;
        end
        a  = model_regs[ins[19:15]];
        b  = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh = b[4:0];
        case (ins[14:12])
            3'd0: res = (is_op && ins[30]) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (ins[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        model_regs[ins[11:7]] = res;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic reset_dut();
        i_rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0; // Model follows the register file clear
        end
    endtask

    task automatic load_program();
        foreach (prog[n]) begin
            i_imem_wen   <= 1'b1;
            i_imem_waddr <= imem_addr_t'(n);
            i_imem_data  <= prog[n];
            @(posedge clk);
        end
        i_imem_wen <= 1'b0;
    endtask

    // Counts the edges at which the DUT sees i_en high
    task automatic run_enabled(input string name, input int target, input bit gaps,
                               output int en_cnt);
        int          cycles;
        logic        en_next;
        logic [31:0] r;
        en_cnt = 0;
        cycles = 0;
        while (en_cnt < target && cycles < target * 4 + 64) begin
            r       = xorshift();
            en_next = !(gaps && r[1:0] == 2'd0);
            if (en_next) begin
                en_cnt++;
            end
            i_en <= en_next;
            @(posedge clk);
            cycles++;
        end
        i_en <= 1'b0;
        if (en_cnt < target) begin
            $display("Timeout in %s: only %0d of %0d enabled cycles after %0d cycles",
                     name, en_cnt, target, cycles);
            err_cnt++;
        end
    endtask

    task automatic read_debug(input reg_addr_t addr, output word_t data);
        i_du_rgfile_rd <= 1'b1;
        i_regfile_addr <= addr;
        @(posedge clk);
        i_du_rgfile_rd <= 1'b0;
        @(negedge clk);
        data = o_regfile_data;
        @(posedge clk);
    endtask

    task automatic compare_regs(input string name);
        word_t data;
        for (int i = 0; i < 32; i++) begin
            read_debug(reg_addr_t'(i), data);
            check_value($sformatf("%s x%0d", name, i), model_regs[i], data);
        end
    endtask

    task automatic sample_pc(output word_t pc);
        @(negedge clk);
        pc = o_pc;
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            test_pass++;
            $display("%s: pass", name);
        end else begin
            test_fail++;
            $display("%s: FAIL with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic run_program(input string name, input int len, input int kind, input bit gaps);
        int    errs_before;
        int    en_cycles;
        word_t pc_seen;
        errs_before = err_cnt;
        reset_dut();
        prog.delete();
        for (int n = 0; n < len; n++) begin
            prog.push_back(gen_instr(kind));
        end
        for (int n = 0; n < NOP_TAIL; n++) begin
            prog.push_back(`RV_NOP); // Drains the pipeline
        end
        foreach (prog[n]) begin
            model_exec(prog[n]);
        end
        load_program();
        run_enabled(name, len + NOP_TAIL, gaps, en_cycles);
        compare_regs(name);
        if (gaps) begin
            sample_pc(pc_seen);
            check_value({name, " o_pc"}, word_t'((4 * en_cycles) % PC_WRAP), pc_seen);
        end
        finish_test(name, errs_before);
    endtask

    initial begin
        word_t pc_seen;
        int    errs_before;
        rng            = 32'd40279;
        err_cnt        = 0;
        test_pass      = 0;
        test_fail      = 0;
        i_rst          = 1'b1;
        i_en           = 1'b0;
        i_imem_wen     = 1'b0;
        i_imem_waddr   = '0;
        i_imem_data    = '0;
        i_du_rgfile_rd = 1'b0;
        i_regfile_addr = '0;

        run_program("reg_reg", 60, K_OP, 1'b0);
        run_program("reg_imm", 60, K_IMM, 1'b0);
        run_program("x0_other", 60, K_X0, 1'b0);

        // Previous program leaves nonzero registers and PC for the reset to clear
        errs_before = err_cnt;
        reset_dut();
        sample_pc(pc_seen);
        check_value("reset o_pc", word_t'(0), pc_seen);
        compare_regs("reset");
        finish_test("reset", errs_before);

        run_program("en_gaps", 252, K_MIX, 1'b1); // Fills the memory so the PC wraps to 0

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_pass + test_fail, test_pass, test_fail, err_cnt);
        if (test_fail == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+.
design/rv_core_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_regfile_wb.sv
design/rv_core.sv
verif/rv_core_chk.sv
verif/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
